/* common/dtlb_macros.svh */
`ifndef DTLB_MACROS_SVH
`define DTLB_MACROS_SVH

// Set index width, low bits of the virtual page number
`define DTLB_SET_BITS 4

// Tag width, the remaining upper bits of the virtual page number
`define DTLB_TAG_BITS 16

// Sets in each way
`define DTLB_NUM_SETS 16

// Associativity
// The eviction scheme keeps one bit per set, so this must stay at two
`define DTLB_WAYS 2

`endif

/* common/dtlb_pkg.sv */
`include "dtlb_macros.svh"

package dtlb_pkg;

   // Virtual page number, tag on top and set index below
   typedef struct packed {
      logic [`DTLB_TAG_BITS-1:0] tag;
      logic [`DTLB_SET_BITS-1:0] set_idx;
   } vpn_t;

   // Physical page number
   typedef logic [19:0] ppn_t;

   // Page flags as stored in the page tables, MSB first
   typedef struct packed {
      logic glob;
      logic kernel;
      logic writeable;
      logic present;
   } page_flags_t;

   // One translation as held in an entry RAM
   typedef struct packed {
      page_flags_t flags;
      ppn_t        ppn;
   } tlb_entry_t;

   // Lookup port, request and response
   typedef struct packed {
      logic re;
      vpn_t vpn;
   } lookup_req_t;

   typedef struct packed {
      ppn_t        ppn;
      page_flags_t flags;
   } lookup_rsp_t;

   // Page table walker, re is a single-cycle strobe
   typedef struct packed {
      logic re;
      vpn_t vpn;
   } ptw_req_t;

   typedef struct packed {
      logic        ready;
      ppn_t        ppn;
      page_flags_t pd_flags;
      page_flags_t pt_flags;
   } ptw_rsp_t;

   // One-hot way vector
   typedef logic [`DTLB_WAYS-1:0] way_sel_t;

endpackage

/* dtlb/dtlb_entry_ram.sv */
`timescale 1ns/1ps

`include "dtlb_macros.svh"

module dtlb_entry_ram (
   input  logic                      clk,
   input  logic [`DTLB_SET_BITS-1:0] addr_a,
   input  logic [`DTLB_SET_BITS-1:0] addr_b,
   input  logic                      we_a,
   input  logic                      we_b,
   input  dtlb_pkg::tlb_entry_t      wdata,
   output dtlb_pkg::tlb_entry_t      q_a,
   output dtlb_pkg::tlb_entry_t      q_b
);

   // Flags and physical page, one word per set
   dtlb_pkg::tlb_entry_t mem [`DTLB_NUM_SETS];

   always_ff @(posedge clk) begin
      if (we_a) mem[addr_a] <= wdata;
      if (we_b) mem[addr_b] <= wdata;
      // Write-first on the writing port
      // The other port sees the new word one read later
      q_a <= we_a ? wdata : mem[addr_a];
      q_b <= we_b ? wdata : mem[addr_b];
   end

   // Fills are serialized by the controller
   a_no_write_clash: assert property (@(posedge clk)
      !(we_a && we_b && (addr_a == addr_b)));

endmodule

/* dtlb/dtlb_tag_store.sv */
`timescale 1ns/1ps

`include "dtlb_macros.svh"

module dtlb_tag_store (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [`DTLB_SET_BITS-1:0] rd_set_a,
   input  logic [`DTLB_SET_BITS-1:0] rd_set_b,
   input  logic [`DTLB_TAG_BITS-1:0] tag_a,
   input  logic [`DTLB_TAG_BITS-1:0] tag_b,
   input  logic                      fill_a,
   input  logic                      fill_b,
   input  dtlb_pkg::way_sel_t        fill_way_a,
   input  dtlb_pkg::way_sel_t        fill_way_b,
   input  logic [`DTLB_TAG_BITS-1:0] fill_tag_a,
   input  logic [`DTLB_TAG_BITS-1:0] fill_tag_b,
   output dtlb_pkg::way_sel_t        hit_a,
   output dtlb_pkg::way_sel_t        hit_b
);

   // Valid bit per set and way
   logic [`DTLB_NUM_SETS-1:0][`DTLB_WAYS-1:0] valid;

   logic [`DTLB_TAG_BITS-1:0] tags [`DTLB_NUM_SETS][`DTLB_WAYS];

   // Registered sets, aligned with the entry RAM read latency
   logic [`DTLB_SET_BITS-1:0] set_a_q;
   logic [`DTLB_SET_BITS-1:0] set_b_q;

   always_ff @(posedge clk) begin
      set_a_q <= rd_set_a;
      set_b_q <= rd_set_b;
   end

   // Fills land on the registered set, which equals the latched one
   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= '0;
      end else begin
         for (int w = 0; w < `DTLB_WAYS; w++) begin
            if (fill_a && fill_way_a[w]) valid[set_a_q][w] <= 1'b1;
            if (fill_b && fill_way_b[w]) valid[set_b_q][w] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int w = 0; w < `DTLB_WAYS; w++) begin
         if (fill_a && fill_way_a[w]) tags[set_a_q][w] <= fill_tag_a;
         if (fill_b && fill_way_b[w]) tags[set_b_q][w] <= fill_tag_b;
      end
   end

   // Hit when the way is valid and its tag matches
   always_comb begin
      for (int w = 0; w < `DTLB_WAYS; w++) begin
         hit_a[w] = valid[set_a_q][w] && (tags[set_a_q][w] == tag_a);
         hit_b[w] = valid[set_b_q][w] && (tags[set_b_q][w] == tag_b);
      end
   end

   // Fills only follow misses, so a tag lives in at most one way
   a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(hit_a) && $onehot0(hit_b));

endmodule

/* dtlb/dtlb_replace.sv */
`timescale 1ns/1ps

`include "dtlb_macros.svh"

module dtlb_replace (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [`DTLB_SET_BITS-1:0] set_a,
   input  logic [`DTLB_SET_BITS-1:0] set_b,
   input  logic                      hit_upd_a,
   input  logic                      hit_upd_b,
   input  dtlb_pkg::way_sel_t        hit_way_a,
   input  dtlb_pkg::way_sel_t        hit_way_b,
   input  logic                      fill_a,
   input  logic                      fill_b,
   output logic                      evict_a,
   output logic                      evict_b
);

   // One bit per set, naming the way that goes next
   logic [`DTLB_NUM_SETS-1:0] evict;

   // Same registered sets as the tag store, i.e. the latched request sets
   logic [`DTLB_SET_BITS-1:0] set_a_q;
   logic [`DTLB_SET_BITS-1:0] set_b_q;

   always_ff @(posedge clk) begin
      set_a_q <= set_a;
      set_b_q <= set_b;
   end

   assign evict_a = evict[set_a_q];
   assign evict_b = evict[set_b_q];

   always_ff @(posedge clk) begin
      if (rst) begin
         evict <= '0;
      end else begin
         // Hit on way 0 points at way 1 and the other way round
         if (hit_upd_a) begin
            evict[set_a_q] <= hit_way_a[0];
         end else if (fill_a) begin
            evict[set_a_q] <= ~evict[set_a_q];
         end
         // B comes later and wins when both ports touch one set
         if (hit_upd_b) begin
            evict[set_b_q] <= hit_way_b[0];
         end else if (fill_b) begin
            evict[set_b_q] <= ~evict[set_b_q];
         end
      end
   end

endmodule

/* dtlb/dtlb_ctrl.sv */
`timescale 1ns/1ps

`include "dtlb_macros.svh"

module dtlb_ctrl (
   input  logic                             clk,
   input  logic                             rst,
   input  dtlb_pkg::lookup_req_t            req_a,
   input  dtlb_pkg::lookup_req_t            req_b,
   output logic                             ready,
   output logic [`DTLB_SET_BITS-1:0]        rd_set_a,
   output logic [`DTLB_SET_BITS-1:0]        rd_set_b,
   input  dtlb_pkg::way_sel_t               hit_a,
   input  dtlb_pkg::way_sel_t               hit_b,
   input  logic                             evict_a,
   input  logic                             evict_b,
   output logic                             hit_upd_a,
   output logic                             hit_upd_b,
   output logic                             fill_a,
   output logic                             fill_b,
   output dtlb_pkg::way_sel_t               fill_way_a,
   output dtlb_pkg::way_sel_t               fill_way_b,
   output logic [`DTLB_TAG_BITS-1:0]        fill_tag_a,
   output logic [`DTLB_TAG_BITS-1:0]        fill_tag_b,
   output dtlb_pkg::tlb_entry_t             fill_entry,
   input  dtlb_pkg::tlb_entry_t             rd_a [`DTLB_WAYS],
   input  dtlb_pkg::tlb_entry_t             rd_b [`DTLB_WAYS],
   output dtlb_pkg::lookup_rsp_t            rsp_a,
   output dtlb_pkg::lookup_rsp_t            rsp_b,
   output dtlb_pkg::ptw_req_t               ptw_req,
   input  dtlb_pkg::ptw_rsp_t               ptw_rsp
);

   typedef enum logic [2:0] {
      st_idle,
      st_comparing,
      st_walk_a,
      st_walk_b,
      st_delay
   } state_t;

   state_t state;
   state_t next_state;

   // Latched request
   logic          re_a_q;
   logic          re_b_q;
   dtlb_pkg::vpn_t vpn_a_q;
   dtlb_pkg::vpn_t vpn_b_q;

   // Way each port's response is read from after the compare cycle
   dtlb_pkg::way_sel_t way_a_q;
   dtlb_pkg::way_sel_t way_b_q;
   dtlb_pkg::way_sel_t sel_a;
   dtlb_pkg::way_sel_t sel_b;

   logic accept;
   logic miss_a;
   logic miss_b;
   logic same_page;
   logic start_a;
   logic start_b;
   logic walking;
   dtlb_pkg::way_sel_t way_evict_a;
   dtlb_pkg::way_sel_t way_evict_b;
   dtlb_pkg::page_flags_t merged;

   // Hit vectors only mean something while comparing or walking
   // Tags change only at a fill edge, so B's miss still holds in walk A
   assign miss_a    = re_a_q && !(|hit_a);
   assign miss_b    = re_b_q && !(|hit_b);
   assign same_page = (vpn_a_q == vpn_b_q);
   assign walking   = (state == st_walk_a) || (state == st_walk_b);

   // Ready while idle, or while comparing when every enabled port hit
   assign ready = (state == st_idle) ||
                  ((state == st_comparing) && !miss_a && !miss_b);
   assign accept = ready && (req_a.re || req_b.re);

   // New sets go straight to the stores on acceptance, else the latched ones
   assign rd_set_a = accept ? req_a.vpn.set_idx : vpn_a_q.set_idx;
   assign rd_set_b = accept ? req_b.vpn.set_idx : vpn_b_q.set_idx;

   assign fill_tag_a = vpn_a_q.tag;
   assign fill_tag_b = vpn_b_q.tag;

   // Eviction bit names the victim way
   assign way_evict_a = {evict_a, ~evict_a};
   assign way_evict_b = {evict_b, ~evict_b};

   always_comb begin
      next_state = state;
      start_a    = 1'b0;
      start_b    = 1'b0;
      fill_a     = 1'b0;
      fill_b     = 1'b0;
      case (state)
         st_idle: begin
            if (accept) next_state = st_comparing;
         end
         st_comparing: begin
            // A is walked first when both ports miss
            if (miss_a) begin
               start_a    = 1'b1;
               next_state = st_walk_a;
            end else if (miss_b) begin
               start_b    = 1'b1;
               next_state = st_walk_b;
            end else if (accept) begin
               next_state = st_comparing;
            end else begin
               next_state = st_idle;
            end
         end
         st_walk_a: begin
            if (ptw_rsp.ready) begin
               fill_a = 1'b1;
               if (miss_b && same_page) begin
                  // B reuses A's entry, one cycle for the cross-port readback
                  next_state = st_delay;
               end else if (miss_b) begin
                  start_b    = 1'b1;
                  next_state = st_walk_b;
               end else begin
                  next_state = st_idle;
               end
            end
         end
         st_walk_b: begin
            if (ptw_rsp.ready) begin
               fill_b     = 1'b1;
               next_state = st_idle;
            end
         end
         default: next_state = st_idle;
      endcase
   end

   assign hit_upd_a = (state == st_comparing) && re_a_q && (|hit_a);
   assign hit_upd_b = (state == st_comparing) && re_b_q && (|hit_b);

   assign fill_way_a = fill_a ? way_evict_a : '0;
   assign fill_way_b = fill_b ? way_evict_b : '0;

   // Present and writeable need both levels, kernel and global either one
   assign merged.glob      = ptw_rsp.pd_flags.glob | ptw_rsp.pt_flags.glob;
   assign merged.kernel    = ptw_rsp.pd_flags.kernel | ptw_rsp.pt_flags.kernel;
   assign merged.writeable = ptw_rsp.pd_flags.writeable & ptw_rsp.pt_flags.writeable;
   assign merged.present   = ptw_rsp.pd_flags.present & ptw_rsp.pt_flags.present;
   assign fill_entry       = '{flags: merged, ppn: ptw_rsp.ppn};

   // Walk address follows the port being walked and holds until ready
   assign ptw_req.re  = start_a || start_b;
   assign ptw_req.vpn = ((state == st_walk_b) || start_b) ? vpn_b_q : vpn_a_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= st_idle;
         re_a_q  <= 1'b0;
         re_b_q  <= 1'b0;
         vpn_a_q <= '0;
         vpn_b_q <= '0;
      end else begin
         state <= next_state;
         if (accept) begin
            re_a_q  <= req_a.re;
            re_b_q  <= req_b.re;
            vpn_a_q <= req_a.vpn;
            vpn_b_q <= req_b.vpn;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_comparing) begin
         way_a_q <= hit_a;
         way_b_q <= hit_b;
      end
      if (fill_a) begin
         way_a_q <= way_evict_a;
         // Same page on B reads the way A just filled
         if (miss_b && same_page) way_b_q <= way_evict_a;
      end
      if (fill_b) way_b_q <= way_evict_b;
   end

   // Compare cycle reads straight from the hit vectors
   assign sel_a = (state == st_comparing) ? hit_a : way_a_q;
   assign sel_b = (state == st_comparing) ? hit_b : way_b_q;

   assign rsp_a = '{ppn: rd_a[sel_a[1]].ppn, flags: rd_a[sel_a[1]].flags};
   assign rsp_b = '{ppn: rd_b[sel_b[1]].ppn, flags: rd_b[sel_b[1]].flags};

   // One cycle per strobe
   // B's walk may start in the very cycle that answers A
   a_ptw_strobe: assert property (@(posedge clk) disable iff (rst)
      ptw_req.re |=> (!ptw_req.re || ptw_rsp.ready));

   // Walker sees a steady address until it answers
   a_ptw_vpn_hold: assert property (@(posedge clk) disable iff (rst)
      (ptw_req.re || (walking && !ptw_rsp.ready)) |=>
         (ptw_rsp.ready || $stable(ptw_req.vpn)));

endmodule

/* dtlb/dtlb_top.sv */
`timescale 1ns/1ps

`include "dtlb_macros.svh"

module dtlb_top (
   input  logic                  clk,
   input  logic                  rst,
   input  dtlb_pkg::lookup_req_t req_a,
   input  dtlb_pkg::lookup_req_t req_b,
   output dtlb_pkg::lookup_rsp_t rsp_a,
   output dtlb_pkg::lookup_rsp_t rsp_b,
   output logic                  ready,
   output dtlb_pkg::ptw_req_t    ptw_req,
   input  dtlb_pkg::ptw_rsp_t    ptw_rsp
);

   // Set indices toward the stores, immediate or latched
   logic [`DTLB_SET_BITS-1:0] rd_set_a;
   logic [`DTLB_SET_BITS-1:0] rd_set_b;

   // Latched tags, compared against and written on fill
   logic [`DTLB_TAG_BITS-1:0] fill_tag_a;
   logic [`DTLB_TAG_BITS-1:0] fill_tag_b;

   dtlb_pkg::way_sel_t   hit_a;
   dtlb_pkg::way_sel_t   hit_b;
   dtlb_pkg::way_sel_t   fill_way_a;
   dtlb_pkg::way_sel_t   fill_way_b;
   logic                 evict_a;
   logic                 evict_b;
   logic                 hit_upd_a;
   logic                 hit_upd_b;
   logic                 fill_a;
   logic                 fill_b;
   dtlb_pkg::tlb_entry_t fill_entry;
   dtlb_pkg::tlb_entry_t rd_a [`DTLB_WAYS];
   dtlb_pkg::tlb_entry_t rd_b [`DTLB_WAYS];

   dtlb_ctrl ctrl_inst (
      .clk        (clk),
      .rst        (rst),
      .req_a      (req_a),
      .req_b      (req_b),
      .ready      (ready),
      .rd_set_a   (rd_set_a),
      .rd_set_b   (rd_set_b),
      .hit_a      (hit_a),
      .hit_b      (hit_b),
      .evict_a    (evict_a),
      .evict_b    (evict_b),
      .hit_upd_a  (hit_upd_a),
      .hit_upd_b  (hit_upd_b),
      .fill_a     (fill_a),
      .fill_b     (fill_b),
      .fill_way_a (fill_way_a),
      .fill_way_b (fill_way_b),
      .fill_tag_a (fill_tag_a),
      .fill_tag_b (fill_tag_b),
      .fill_entry (fill_entry),
      .rd_a       (rd_a),
      .rd_b       (rd_b),
      .rsp_a      (rsp_a),
      .rsp_b      (rsp_b),
      .ptw_req    (ptw_req),
      .ptw_rsp    (ptw_rsp)
   );

   dtlb_tag_store tag_store_inst (
      .clk        (clk),
      .rst        (rst),
      .rd_set_a   (rd_set_a),
      .rd_set_b   (rd_set_b),
      .tag_a      (fill_tag_a),
      .tag_b      (fill_tag_b),
      .fill_a     (fill_a),
      .fill_b     (fill_b),
      .fill_way_a (fill_way_a),
      .fill_way_b (fill_way_b),
      .fill_tag_a (fill_tag_a),
      .fill_tag_b (fill_tag_b),
      .hit_a      (hit_a),
      .hit_b      (hit_b)
   );

   dtlb_replace replace_inst (
      .clk       (clk),
      .rst       (rst),
      .set_a     (rd_set_a),
      .set_b     (rd_set_b),
      .hit_upd_a (hit_upd_a),
      .hit_upd_b (hit_upd_b),
      .hit_way_a (hit_a),
      .hit_way_b (hit_b),
      .fill_a    (fill_a),
      .fill_b    (fill_b),
      .evict_a   (evict_a),
      .evict_b   (evict_b)
   );

   // One entry RAM per way, write enables come from the one-hot fill ways
   for (genvar w = 0; w < `DTLB_WAYS; w++) begin : g_way
      dtlb_entry_ram entry_ram_inst (
         .clk    (clk),
         .addr_a (rd_set_a),
         .addr_b (rd_set_b),
         .we_a   (fill_way_a[w]),
         .we_b   (fill_way_b[w]),
         .wdata  (fill_entry),
         .q_a    (rd_a[w]),
         .q_b    (rd_b[w])
      );
   end

endmodule

/* dv/tb_dtlb_util.svh */
`ifndef TB_DTLB_UTIL_SVH
`define TB_DTLB_UTIL_SVH

// Random source, one step per bit taken
logic [31:0] lfsr = 32'h8b16;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   // Galois form of x^32 + x^22 + x^2 + x + 1
   return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
   end
   return v;
endfunction

// Page table contents as the walker model serves them
function automatic dtlb_pkg::ppn_t translate_ppn(input dtlb_pkg::vpn_t vpn);
   return vpn ^ 20'h5a3c1;
endfunction

function automatic dtlb_pkg::page_flags_t pd_flags_of(input dtlb_pkg::vpn_t vpn);
   logic [19:0] v;
   v = vpn;
   return dtlb_pkg::page_flags_t'(v[3:0] ^ 4'b0011);
endfunction

function automatic dtlb_pkg::page_flags_t pt_flags_of(input dtlb_pkg::vpn_t vpn);
   logic [19:0] v;
   v = vpn;
   return dtlb_pkg::page_flags_t'(v[6:3] ^ 4'b0101);
endfunction

// Both levels needed for present and writeable, either one for kernel and global
function automatic dtlb_pkg::page_flags_t merge_flags(input dtlb_pkg::page_flags_t pd,
                                                      input dtlb_pkg::page_flags_t pt);
   dtlb_pkg::page_flags_t m;
   m.present   = pd.present & pt.present;
   m.writeable = pd.writeable & pt.writeable;
   m.kernel    = pd.kernel | pt.kernel;
   m.glob      = pd.glob | pt.glob;
   return m;
endfunction

function automatic dtlb_pkg::lookup_rsp_t expected_rsp(input dtlb_pkg::vpn_t vpn);
   dtlb_pkg::lookup_rsp_t r;
   r.ppn   = translate_ppn(vpn);
   r.flags = merge_flags(pd_flags_of(vpn), pt_flags_of(vpn));
   return r;
endfunction

// Golden TLB state
logic                      m_valid [`DTLB_NUM_SETS][`DTLB_WAYS];
logic [`DTLB_TAG_BITS-1:0] m_tag   [`DTLB_NUM_SETS][`DTLB_WAYS];
logic                      m_evict [`DTLB_NUM_SETS];
dtlb_pkg::vpn_t            exp_walks[$];
int                        exp_total = 0;

task automatic model_reset();
   for (int s = 0; s < `DTLB_NUM_SETS; s++) begin
      m_evict[s] = 1'b0;
      for (int w = 0; w < `DTLB_WAYS; w++) begin
         m_valid[s][w] = 1'b0;
         m_tag[s][w]   = '0;
      end
   end
endtask

function automatic int model_find(input dtlb_pkg::vpn_t vpn);
   for (int w = 0; w < `DTLB_WAYS; w++) begin
      if (m_valid[vpn.set_idx][w] && (m_tag[vpn.set_idx][w] == vpn.tag)) return w;
   end
   return -1;
endfunction

// Fill the way the set's bit names, then flip the bit
task automatic model_fill(input dtlb_pkg::vpn_t vpn);
   int w;
   w = int'(m_evict[vpn.set_idx]);
   m_valid[vpn.set_idx][w] = 1'b1;
   m_tag[vpn.set_idx][w]   = vpn.tag;
   m_evict[vpn.set_idx]    = (w == 0);
   exp_walks.push_back(vpn);
   exp_total++;
endtask

task automatic model_access(input dtlb_pkg::lookup_req_t ra, input dtlb_pkg::lookup_req_t rb);
   int  wa;
   int  wb;
   logic miss_a;
   logic miss_b;
   wa = ra.re ? model_find(ra.vpn) : -1;
   wb = rb.re ? model_find(rb.vpn) : -1;
   miss_a = ra.re && (wa < 0);
   miss_b = rb.re && (wb < 0);
   // Hits point their set at the other way, port B last
   if (wa >= 0) m_evict[ra.vpn.set_idx] = (wa == 0);
   if (wb >= 0) m_evict[rb.vpn.set_idx] = (wb == 0);
   if (miss_a) model_fill(ra.vpn);
   // A shared page is walked once
   if (miss_b && !(miss_a && (ra.vpn == rb.vpn))) model_fill(rb.vpn);
endtask

task automatic check_rsp(input string name, input dtlb_pkg::lookup_rsp_t got,
                         input dtlb_pkg::lookup_rsp_t want);
   checks++;
   if (got !== want) begin
      errors++;
      $display("ERROR at %0t: %s got ppn %h flags %b, expected ppn %h flags %b",
               $time, name, got.ppn, got.flags, want.ppn, want.flags);
   end
endtask

task automatic check_ptw(input string name, input dtlb_pkg::ptw_req_t got,
                         input dtlb_pkg::ptw_req_t want);
   checks++;
   if (got !== want) begin
      errors++;
      $display("ERROR at %0t: %s got re %b vpn %h, expected re %b vpn %h",
               $time, name, got.re, got.vpn, want.re, want.vpn);
   end
endtask

task automatic check_count(input string name, input int got, input int want);
   checks++;
   if (got != want) begin
      errors++;
      $display("ERROR at %0t: %s got %0d, expected %0d", $time, name, got, want);
   end
endtask

`endif

/* dv/tb_dtlb.sv */
`timescale 1ns/1ps

`include "dtlb_macros.svh"

module tb_dtlb;

   localparam int wait_limit = 60;

   logic                  clk;
   logic                  rst;
   dtlb_pkg::lookup_req_t req_a;
   dtlb_pkg::lookup_req_t req_b;
   dtlb_pkg::lookup_rsp_t rsp_a;
   dtlb_pkg::lookup_rsp_t rsp_b;
   logic                  ready;
   dtlb_pkg::ptw_req_t    ptw_req;
   dtlb_pkg::ptw_rsp_t    ptw_rsp;

   int errors = 0;
   int checks = 0;
   int tests = 0;
   int walk_count = 0;

   // Walks the walker saw during the current access
   dtlb_pkg::ptw_req_t seen_walks[$];

   `include "tb_dtlb_util.svh"

   dtlb_top dtlb_top_inst (
      .clk     (clk),
      .rst     (rst),
      .req_a   (req_a),
      .req_b   (req_b),
      .rsp_a   (rsp_a),
      .rsp_b   (rsp_b),
      .ready   (ready),
      .ptw_req (ptw_req),
      .ptw_rsp (ptw_rsp)
   );

   always #5 clk = ~clk;

   // Walker, answers each strobe after 1 to 8 cycles
   initial begin
      int             countdown;
      dtlb_pkg::vpn_t pend_vpn;
      dtlb_pkg::ptw_req_t held;
      countdown = 0;
      pend_vpn  = '0;
      ptw_rsp   = '0;
      forever begin
         @(negedge clk);
         if (countdown == 1) begin
            ptw_rsp.ready    = 1'b1;
            ptw_rsp.ppn      = translate_ppn(pend_vpn);
            ptw_rsp.pd_flags = pd_flags_of(pend_vpn);
            ptw_rsp.pt_flags = pt_flags_of(pend_vpn);
            countdown        = 0;
         end else begin
            ptw_rsp = '0;
            if (countdown > 1) countdown--;
         end
         // Request side settles after the response drive
         #1;
         if (countdown > 0) begin
            held.re  = 1'b0;
            held.vpn = pend_vpn;
            check_ptw("ptw_req while walking", ptw_req, held);
         end else if (!rst && (ptw_req.re === 1'b1)) begin
            seen_walks.push_back(ptw_req);
            walk_count++;
            pend_vpn  = ptw_req.vpn;
            countdown = 1 + int'(rand_bits(3));
         end
      end
   end

   task automatic stop_on_timeout(input string what);
      $display("Timeout at %0t: %s", $time, what);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   function automatic dtlb_pkg::lookup_req_t make_req(input logic re, input logic [19:0] v);
      dtlb_pkg::lookup_req_t r;
      r.re  = re;
      r.vpn = v;
      return r;
   endfunction

   // Called at a falling edge, returns at the falling edge of the response cycle
   task automatic run_access(input string name, input dtlb_pkg::lookup_req_t ra,
                             input dtlb_pkg::lookup_req_t rb, input int want_walks);
      dtlb_pkg::lookup_rsp_t got_a;
      dtlb_pkg::lookup_rsp_t got_b;
      dtlb_pkg::ptw_req_t    want_req;
      int lat;
      int n;
      exp_walks.delete();
      seen_walks.delete();
      model_access(ra, rb);
      n = 0;
      while (ready !== 1'b1) begin
         n++;
         if (n > wait_limit) stop_on_timeout({name, ": ready stayed low before the request"});
         @(negedge clk);
      end
      req_a = ra;
      req_b = rb;
      @(negedge clk);
      req_a = '0;
      req_b = '0;
      lat = 1;
      while (ready !== 1'b1) begin
         lat++;
         if (lat > wait_limit) stop_on_timeout({name, ": no response to the request"});
         @(negedge clk);
      end
      got_a = rsp_a;
      got_b = rsp_b;
      if (ra.re) check_rsp({name, " rsp_a"}, got_a, expected_rsp(ra.vpn));
      if (rb.re) check_rsp({name, " rsp_b"}, got_b, expected_rsp(rb.vpn));
      check_count({name, " walk count"}, seen_walks.size(), exp_walks.size());
      if (want_walks >= 0) check_count({name, " walks"}, seen_walks.size(), want_walks);
      for (int i = 0; i < seen_walks.size() && i < exp_walks.size(); i++) begin
         want_req.re  = 1'b1;
         want_req.vpn = exp_walks[i];
         check_ptw({name, " ptw_req"}, seen_walks[i], want_req);
      end
      // All hits answer in the cycle after acceptance
      if ((exp_walks.size() == 0) && (lat != 1)) begin
         errors++;
         $display("%s: request that hit took %0d cycles instead of 1", name, lat);
      end
   endtask

   // Small pool of 16 pages over 4 sets keeps evictions frequent
   task automatic random_run(input int count);
      logic [15:0] tag;
      logic [3:0]  set;
      logic [19:0] va;
      logic [19:0] vb;
      logic        ea;
      logic        eb;
      for (int i = 0; i < count; i++) begin
         tag = 16'h0100 + 16'(rand_bits(2));
         set = 4'(rand_bits(2));
         va  = {tag, set};
         tag = 16'h0100 + 16'(rand_bits(2));
         set = 4'(rand_bits(2));
         vb  = {tag, set};
         if (rand_bits(3) == 0) vb = va;
         ea = (rand_bits(1) != 0);
         eb = (rand_bits(1) != 0);
         if (!ea && !eb) ea = 1'b1;
         run_access($sformatf("random %0d", i), make_req(ea, va), make_req(eb, vb), -1);
      end
   endtask

   task automatic end_test(input string name, input int mark);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == mark) ? "pass" : "fail");
   endtask

   initial begin
      int mark;
      clk   = 1'b0;
      rst   = 1'b1;
      req_a = '0;
      req_b = '0;
      model_reset();
      repeat (2) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      mark = errors;
      checks++;
      if (ready !== 1'b1) begin
         errors++;
         $display("ERROR at %0t: ready got %b, expected 1", $time, ready);
      end
      checks++;
      if (ptw_req.re !== 1'b0) begin
         errors++;
         $display("ERROR at %0t: ptw_req.re got %b, expected 0", $time, ptw_req.re);
      end
      check_count("walks after reset", walk_count, 0);
      end_test("reset", mark);

      mark = errors;
      run_access("miss on A", make_req(1'b1, 20'h12343), make_req(1'b0, 20'h0), 1);
      run_access("repeat on A", make_req(1'b1, 20'h12343), make_req(1'b0, 20'h0), 0);
      run_access("miss on B", make_req(1'b0, 20'h0), make_req(1'b1, 20'h4567a), 1);
      end_test("single port miss", mark);

      mark = errors;
      run_access("two misses", make_req(1'b1, 20'h2222b), make_req(1'b1, 20'h3333c), 2);
      end_test("two ports, two pages", mark);

      mark = errors;
      run_access("shared miss", make_req(1'b1, 20'h77770), make_req(1'b1, 20'h77770), 1);
      end_test("two ports, one page", mark);

      // Set 5 with three tags, the third evicts the first
      mark = errors;
      run_access("set5 tag a1", make_req(1'b1, 20'h00a15), make_req(1'b0, 20'h0), 1);
      run_access("set5 tag b1", make_req(1'b1, 20'h00b15), make_req(1'b0, 20'h0), 1);
      run_access("set5 tag c1", make_req(1'b1, 20'h00c15), make_req(1'b0, 20'h0), 1);
      run_access("set5 kept b1", make_req(1'b1, 20'h00b15), make_req(1'b0, 20'h0), 0);
      run_access("set5 evicted a1", make_req(1'b1, 20'h00a15), make_req(1'b0, 20'h0), 1);
      end_test("replacement", mark);

      mark = errors;
      random_run(300);
      check_count("total walks", walk_count, exp_total);
      end_test("random", mark);

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+common
+incdir+dv
common/dtlb_pkg.sv
dtlb/dtlb_entry_ram.sv
dtlb/dtlb_tag_store.sv
dtlb/dtlb_replace.sv
dtlb/dtlb_ctrl.sv
dtlb/dtlb_top.sv
dv/tb_dtlb.sv
